// ==== hdl/rv32_pkg.sv ====
`default_nettype none

package rv32_pkg;

  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;
  localparam int alu_op_w   = 4;
  localparam int wb_sel_w   = 2;

  localparam logic [xlen-1:0] reset_pc = '0;

  // Major opcodes
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;

  // ALU funct3, shared by register and immediate forms
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;

  // Branch funct3
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd3;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd4;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd8;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd9;
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  localparam logic [wb_sel_w-1:0] wb_alu = 2'd0;
  localparam logic [wb_sel_w-1:0] wb_mem = 2'd1;
  localparam logic [wb_sel_w-1:0] wb_pc4 = 2'd2;

  // One instruction word, one view per encoding format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } instr_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_dec_if.sv ====
`default_nettype none

interface fetch_dec_if import rv32_pkg::*; ();

  // IF/ID register content
  logic            valid;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] instr;

  // Load-use hold request from decode
  logic            stall;

  modport fetch (output valid, output pc, output instr, input stall);

  modport decode (input valid, input pc, input instr, output stall);

endinterface

`default_nettype wire

// ==== hdl/dec_exe_if.sv ====
`default_nettype none

interface dec_exe_if import rv32_pkg::*; ();

  // ID/EX register, owned by decode
  logic                  valid;
  logic [xlen-1:0]       pc;
  logic [xlen-1:0]       rs1_val;
  logic [xlen-1:0]       rs2_val;
  logic [xlen-1:0]       imm;
  logic [reg_addr_w-1:0] rd;
  logic [alu_op_w-1:0]   alu_op;
  logic                  op2_imm;
  logic [wb_sel_w-1:0]   wb_sel;
  logic                  reg_write;
  logic                  mem_read;
  logic                  mem_write;
  logic                  branch;
  logic                  jump;
  logic                  jalr;
  logic [2:0]            funct3;

  // Write-back and redirect, flowing back from execute
  logic                  wb_en;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;
  logic                  wb_is_load;
  logic                  redirect;
  logic [xlen-1:0]       target;

  modport decode (
    output valid, pc, rs1_val, rs2_val, imm, rd, alu_op, op2_imm, wb_sel,
    output reg_write, mem_read, mem_write, branch, jump, jalr, funct3,
    input  wb_en, wb_rd, wb_data, wb_is_load, redirect, target
  );

  modport execute (
    input  valid, pc, rs1_val, rs2_val, imm, rd, alu_op, op2_imm, wb_sel,
    input  reg_write, mem_read, mem_write, branch, jump, jalr, funct3,
    output wb_en, wb_rd, wb_data, wb_is_load, redirect, target
  );

endinterface

`default_nettype wire

// ==== hdl/fetch_stage.sv ====
`default_nettype none

module fetch_stage import rv32_pkg::*; (
  input  logic             clk,
  input  logic             rst,
  input  logic             redirect,
  input  logic [xlen-1:0]  target,
  output logic [xlen-1:0]  instr_addr,
  input  logic [xlen-1:0]  instr_rdata,
  fetch_dec_if.fetch       fd
);

  logic [xlen-1:0] pc;

  assign instr_addr = pc;

  // PC and IF/ID valid; a redirect drops the word fetched this cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc       <= reset_pc;
      fd.valid <= 1'b0;
    end else if (redirect) begin
      pc       <= target;
      fd.valid <= 1'b0;
    end else if (!fd.stall) begin
      pc       <= pc + xlen'(4);
      fd.valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!fd.stall) begin
      fd.pc    <= pc;
      fd.instr <= instr_rdata;
    end
  end

  // Execute only ever hands back word-aligned targets
  pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`default_nettype none

module decode_stage import rv32_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  fetch_dec_if.decode fd,
  dec_exe_if.decode   de
);

  instr_t ir;

  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [2:0]            funct3;

  logic [alu_op_w-1:0] alu_op_d;
  logic                op2_imm_d;
  logic [wb_sel_w-1:0] wb_sel_d;
  logic                reg_write_d;
  logic                mem_read_d;
  logic                mem_write_d;
  logic                branch_d;
  logic                jump_d;
  logic                jalr_d;
  logic                use_rs1;
  logic                use_rs2;
  logic [xlen-1:0]     imm_d;

  logic [xlen-1:0] regs [1:31];
  logic [xlen-1:0] rf_rs1;
  logic [xlen-1:0] rf_rs2;
  logic            hit_rs1;
  logic            hit_rs2;

  function automatic logic [alu_op_w-1:0] alu_from_f3(input logic [2:0] f3, input logic alt);
    logic [alu_op_w-1:0] op;
    case (f3)
      f3_add:  op = alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      default: op = alu_and;
    endcase
    return op;
  endfunction

  assign ir     = fd.instr;
  assign rs1    = ir.r.rs1;
  assign rs2    = ir.r.rs2;
  assign rd     = ir.r.rd;
  assign funct3 = ir.r.funct3;

  always_comb begin
    alu_op_d    = alu_add;
    op2_imm_d   = 1'b0;
    wb_sel_d    = wb_alu;
    reg_write_d = 1'b0;
    mem_read_d  = 1'b0;
    mem_write_d = 1'b0;
    branch_d    = 1'b0;
    jump_d      = 1'b0;
    jalr_d      = 1'b0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    imm_d       = {{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0};
    case (ir.r.opcode)
      op_reg: begin
        alu_op_d    = alu_from_f3(funct3, ir.r.funct7[5]);
        reg_write_d = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      op_imm: begin
        // Bit 30 only means arithmetic shift for srai
        alu_op_d    = alu_from_f3(funct3, funct3 == f3_sr && ir.r.funct7[5]);
        op2_imm_d   = 1'b1;
        reg_write_d = 1'b1;
        use_rs1     = 1'b1;
      end
      op_lui: begin
        alu_op_d    = alu_pass_b;
        op2_imm_d   = 1'b1;
        reg_write_d = 1'b1;
        imm_d       = {ir.u.imm_31_12, 12'b0};
      end
      op_load: begin
        op2_imm_d   = 1'b1;
        wb_sel_d    = wb_mem;
        reg_write_d = 1'b1;
        mem_read_d  = 1'b1;
        use_rs1     = 1'b1;
      end
      op_store: begin
        op2_imm_d   = 1'b1;
        mem_write_d = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        imm_d       = {{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0};
      end
      op_branch: begin
        branch_d = 1'b1;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        imm_d    = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11, ir.b.imm_10_5,
                    ir.b.imm_4_1, 1'b0};
      end
      op_jal: begin
        wb_sel_d    = wb_pc4;
        reg_write_d = 1'b1;
        jump_d      = 1'b1;
        imm_d       = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12, ir.j.imm_11,
                       ir.j.imm_10_1, 1'b0};
      end
      op_jalr: begin
        wb_sel_d    = wb_pc4;
        reg_write_d = 1'b1;
        jump_d      = 1'b1;
        jalr_d      = 1'b1;
        use_rs1     = 1'b1;
      end
      default: ;
    endcase
    // Writes to x0 are dropped here, so write-back never names it
    if (rd == '0) begin
      reg_write_d = 1'b0;
    end
  end

  // x1..x31 only, x0 reads as zero
  always_ff @(posedge clk) begin
    if (de.wb_en) begin
      regs[de.wb_rd] <= de.wb_data;
    end
  end

  assign rf_rs1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rf_rs2 = (rs2 == '0) ? '0 : regs[rs2];

  assign hit_rs1 = de.wb_en && de.wb_rd == rs1 && rs1 != '0;
  assign hit_rs2 = de.wb_en && de.wb_rd == rs2 && rs2 != '0;

  // Load result arrives too late to forward
  assign fd.stall = fd.valid && de.wb_is_load && ((hit_rs1 && use_rs1) || (hit_rs2 && use_rs2));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      de.valid <= 1'b0;
    end else begin
      de.valid <= fd.valid && !fd.stall && !de.redirect;
    end
  end

  always_ff @(posedge clk) begin
    de.pc        <= fd.pc;
    de.rs1_val   <= (hit_rs1 && !de.wb_is_load) ? de.wb_data : rf_rs1;
    de.rs2_val   <= (hit_rs2 && !de.wb_is_load) ? de.wb_data : rf_rs2;
    de.imm       <= imm_d;
    de.rd        <= rd;
    de.alu_op    <= alu_op_d;
    de.op2_imm   <= op2_imm_d;
    de.wb_sel    <= wb_sel_d;
    de.reg_write <= reg_write_d;
    de.mem_read  <= mem_read_d;
    de.mem_write <= mem_write_d;
    de.branch    <= branch_d;
    de.jump      <= jump_d;
    de.jalr      <= jalr_d;
    de.funct3    <= funct3;
  end

  // A stall only sits behind a load, and a load never redirects
  stall_on_load: assert property (@(posedge clk) disable iff (rst)
    fd.stall |-> de.wb_is_load && !de.redirect);

  // Write-back coming round from execute never targets x0
  no_x0_write: assert property (@(posedge clk) disable iff (rst) de.wb_en |-> de.wb_rd != '0);

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`default_nettype none

module execute_stage import rv32_pkg::*; (
  dec_exe_if.execute      de,
  output logic [xlen-1:0] data_addr,
  output logic [xlen-1:0] data_wdata,
  output logic            data_we,
  output logic            data_re,
  input  logic [xlen-1:0] data_rdata
);

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] pc_plus4;
  logic            cond;
  logic            taken;

  assign op_a     = de.rs1_val;
  assign op_b     = de.op2_imm ? de.imm : de.rs2_val;
  assign pc_plus4 = de.pc + xlen'(4);

  always_comb begin
    case (de.alu_op)
      alu_add:    alu_res = op_a + op_b;
      alu_sub:    alu_res = op_a - op_b;
      alu_and:    alu_res = op_a & op_b;
      alu_or:     alu_res = op_a | op_b;
      alu_xor:    alu_res = op_a ^ op_b;
      alu_slt:    alu_res = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_res = {{(xlen-1){1'b0}}, op_a < op_b};
      alu_sll:    alu_res = op_a << op_b[4:0];
      alu_srl:    alu_res = op_a >> op_b[4:0];
      alu_sra:    alu_res = $signed(op_a) >>> op_b[4:0];
      alu_pass_b: alu_res = op_b;
      default:    alu_res = '0;
    endcase
  end

  // Branch compare works on the raw register operands
  always_comb begin
    case (de.funct3)
      f3_beq:  cond = de.rs1_val == de.rs2_val;
      f3_bne:  cond = de.rs1_val != de.rs2_val;
      f3_blt:  cond = $signed(de.rs1_val) < $signed(de.rs2_val);
      f3_bge:  cond = $signed(de.rs1_val) >= $signed(de.rs2_val);
      f3_bltu: cond = de.rs1_val < de.rs2_val;
      f3_bgeu: cond = de.rs1_val >= de.rs2_val;
      default: cond = 1'b0;
    endcase
  end

  assign taken = de.valid && (de.jump || (de.branch && cond));

  assign de.redirect = taken;
  assign de.target   = de.jalr ? ((de.rs1_val + de.imm) & ~xlen'(1)) : (de.pc + de.imm);

  // Loads and stores use the ALU add for their address
  assign data_addr  = alu_res;
  assign data_wdata = de.rs2_val;
  assign data_we    = de.valid && de.mem_write;
  assign data_re    = de.valid && de.mem_read;

  always_comb begin
    case (de.wb_sel)
      wb_mem:  de.wb_data = data_rdata;
      wb_pc4:  de.wb_data = pc_plus4;
      default: de.wb_data = alu_res;
    endcase
  end

  assign de.wb_en      = de.valid && de.reg_write;
  assign de.wb_rd      = de.rd;
  assign de.wb_is_load = de.valid && de.mem_read;

  // Decode never sets both memory controls for one instruction
  always_comb begin
    mem_exclusive: assert final (!(data_we && data_re));
  end

endmodule

`default_nettype wire

// ==== hdl/rv32_core.sv ====
`default_nettype none

module rv32_core import rv32_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  // Instruction memory
  output logic [xlen-1:0] instr_addr,
  input  logic [xlen-1:0] instr_rdata,
  // Data memory
  output logic [xlen-1:0] data_addr,
  output logic [xlen-1:0] data_wdata,
  output logic            data_we,
  output logic            data_re,
  input  logic [xlen-1:0] data_rdata
);

  fetch_dec_if fd_bus ();
  dec_exe_if   de_bus ();

  // Redirect is raised by execute and steers the PC directly
  fetch_stage u_fetch (
    .clk         (clk),
    .rst         (rst),
    .redirect    (de_bus.redirect),
    .target      (de_bus.target),
    .instr_addr  (instr_addr),
    .instr_rdata (instr_rdata),
    .fd          (fd_bus.fetch)
  );

  decode_stage u_decode (
    .clk (clk),
    .rst (rst),
    .fd  (fd_bus.decode),
    .de  (de_bus.decode)
  );

  execute_stage u_execute (
    .de         (de_bus.execute),
    .data_addr  (data_addr),
    .data_wdata (data_wdata),
    .data_we    (data_we),
    .data_re    (data_re),
    .data_rdata (data_rdata)
  );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rst
);

  timeunit 1ns;
  timeprecision 1ps;

  // 40 ns period
  initial begin
    clk = 1'b0;
    rst = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic hold_reset();
    rst = 1'b1;
  endtask

  // Reset spans three rising edges and drops just after the last one
  task automatic release_reset();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

endmodule

`default_nettype wire

// ==== tb/core_mem_model.sv ====
`default_nettype none

module core_mem_model import rv32_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic [xlen-1:0] instr_addr,
  output logic [xlen-1:0] instr_rdata,
  input  logic [xlen-1:0] data_addr,
  input  logic [xlen-1:0] data_wdata,
  input  logic            data_we,
  input  logic            data_re,
  output logic [xlen-1:0] data_rdata
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int depth = 256;

  logic [xlen-1:0] rom [depth];
  logic [xlen-1:0] ram [depth];
  logic [xlen-1:0] store_count;

  // A misaligned fetch reads as zero, which the core treats as no operation
  assign instr_rdata = (instr_addr[1:0] == 2'b00) ? rom[instr_addr[9:2]] : '0;
  assign data_rdata  = data_re ? ram[data_addr[9:2]] : '0;

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      store_count <= '0;
    end else if (data_we) begin
      ram[data_addr[9:2]] <= data_wdata;
      store_count         <= store_count + 1;
    end
  end

  task automatic put_rom(input int idx, input logic [xlen-1:0] word);
    rom[idx] = word;
  endtask

  task automatic put_ram(input int idx, input logic [xlen-1:0] word);
    ram[idx] = word;
  endtask

endmodule

`default_nettype wire

// ==== tb/rv32_core_tb.sv ====
`default_nettype none

module rv32_core_tb import rv32_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] marker = 32'h0c0d_e000;

  logic        clk;
  logic        rst;
  logic [31:0] instr_addr;
  logic [31:0] instr_rdata;
  logic [31:0] data_addr;
  logic [31:0] data_wdata;
  logic        data_we;
  logic        data_re;
  logic [31:0] data_rdata;

  int unsigned n_tests;
  int unsigned n_checks;
  int unsigned n_errors;
  int unsigned pc_idx;
  logic [31:0] expect_q [$];

  tb_clock clkgen (.clk(clk), .rst(rst));

  core_mem_model mem (
    .clk(clk), .rst(rst), .instr_addr(instr_addr), .instr_rdata(instr_rdata),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_we(data_we),
    .data_re(data_re), .data_rdata(data_rdata)
  );

  rv32_core DUT (
    .clk(clk), .rst(rst), .instr_addr(instr_addr), .instr_rdata(instr_rdata),
    .data_addr(data_addr), .data_wdata(data_wdata), .data_we(data_we),
    .data_re(data_re), .data_rdata(data_rdata)
  );

  function automatic instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                   input logic [4:0] rd, rs1, rs2);
    instr_t w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = op_reg;
    return w;
  endfunction

  function automatic instr_t enc_i(input logic [6:0] op, input logic [2:0] f3,
                                   input logic [4:0] rd, rs1, input logic [11:0] imm);
    instr_t w;
    w.i.imm_11_0 = imm;
    w.i.rs1      = rs1;
    w.i.funct3   = f3;
    w.i.rd       = rd;
    w.i.opcode   = op;
    return w;
  endfunction

  function automatic instr_t sw(input logic [4:0] rs2, rs1, input logic [11:0] imm);
    instr_t w;
    w.s.imm_11_5 = imm[11:5];
    w.s.rs2      = rs2;
    w.s.rs1      = rs1;
    w.s.funct3   = 3'b010;
    w.s.imm_4_0  = imm[4:0];
    w.s.opcode   = op_store;
    return w;
  endfunction

  function automatic instr_t enc_b(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                   input logic [12:0] imm);
    instr_t w;
    w.b.imm_12   = imm[12];
    w.b.imm_10_5 = imm[10:5];
    w.b.rs2      = rs2;
    w.b.rs1      = rs1;
    w.b.funct3   = f3;
    w.b.imm_4_1  = imm[4:1];
    w.b.imm_11   = imm[11];
    w.b.opcode   = op_branch;
    return w;
  endfunction

  function automatic instr_t enc_u(input logic [4:0] rd, input logic [19:0] imm);
    instr_t w;
    w.u.imm_31_12 = imm;
    w.u.rd        = rd;
    w.u.opcode    = op_lui;
    return w;
  endfunction

  function automatic instr_t enc_j(input logic [4:0] rd, input logic [20:0] imm);
    instr_t w;
    w.j.imm_20    = imm[20];
    w.j.imm_10_1  = imm[10:1];
    w.j.imm_11    = imm[11];
    w.j.imm_19_12 = imm[19:12];
    w.j.rd        = rd;
    w.j.opcode    = op_jal;
    return w;
  endfunction

  function automatic instr_t addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return enc_i(op_imm, f3_add, rd, rs1, imm);
  endfunction

  function automatic instr_t lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
    return enc_i(op_load, 3'b010, rd, rs1, imm);
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'hbad0_0000 | 32'(idx);
  endfunction

  // Operands of opposite sign decide by the sign bit alone
  function automatic logic [31:0] signed_less(input logic [31:0] x, input logic [31:0] y);
    if (x[31] != y[31]) begin
      return {31'b0, x[31]};
    end
    return {31'b0, x < y};
  endfunction

  // Logical shift with the vacated upper bits filled from the sign
  function automatic logic [31:0] shift_right_arith(input logic [31:0] x, input logic [4:0] n);
    logic [31:0] fill;
    fill = x[31] ? ~(32'hffff_ffff >> n) : 32'h0;
    return (x >> n) | fill;
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("** Error: %s = %h, expected %h", what, got, exp);
    end
  endtask

  task automatic emit(input instr_t w);
    mem.put_rom(pc_idx, w);
    pc_idx++;
  endtask

  // Core held in reset while both memories are refilled
  task automatic start_program();
    @(posedge clk);
    #1;
    clkgen.hold_reset();
    for (int i = 0; i < 256; i++) begin
      mem.put_rom(i, addi(5'd0, 5'd0, 12'(i)));
      mem.put_ram(i, fill_word(i));
    end
    pc_idx = 0;
    expect_q.delete();
  endtask

  // Ends the program with the marker store and a self loop, then runs it
  task automatic run_program(output bit done);
    int cycles;
    emit(enc_u(5'd31, marker[31:12]));
    emit(sw(5'd31, 5'd0, 12'h3fc));
    emit(enc_j(5'd0, 21'd0));
    clkgen.release_reset();
    done = 1'b0;
    for (cycles = 0; cycles < 500 && !done; cycles++) begin
      @(posedge clk);
      #1;
      done = (mem.ram[255] == marker);
    end
    if (!done) begin
      n_errors++;
      $display("Timeout: program never stored its end marker within 500 cycles");
    end
  endtask

  task automatic check_slots(input int first, input int count);
    for (int k = 0; k < count; k++) begin
      check($sformatf("ram[%0d]", first + k), mem.ram[first + k],
            (k < expect_q.size()) ? expect_q[k] : fill_word(first + k));
    end
  endtask

  task automatic end_test(input string name, input int unsigned err_mark);
    n_tests++;
    $display("test %-12s done, %0d error(s)", name, n_errors - err_mark);
  endtask

  task automatic test_reset_state();
    int unsigned err_mark;
    err_mark = n_errors;
    check("instr_addr", instr_addr, 32'h0);
    check("data_we", 32'(data_we), 32'h0);
    check("data_re", 32'(data_re), 32'h0);
    end_test("reset_state", err_mark);
  endtask

  // Result goes to x3 and is stored to the next free slot from word 16
  task automatic alu_case(input instr_t w, input logic [31:0] exp);
    emit(w);
    emit(sw(5'd3, 5'd0, 12'(64 + 4 * expect_q.size())));
    expect_q.push_back(exp);
  endtask

  task automatic test_alu();
    logic [31:0] a, b, iv;
    logic [11:0] imm;
    logic [4:0]  sh;
    logic [19:0] up;
    bit          done;
    int unsigned err_mark;
    err_mark = n_errors;
    a   = $urandom();
    b   = $urandom();
    imm = 12'($urandom());
    sh  = 5'($urandom());
    up  = 20'($urandom());
    iv  = {{20{imm[11]}}, imm};
    start_program();
    mem.put_ram(0, a);
    mem.put_ram(1, b);
    emit(lw(5'd1, 5'd0, 12'd0));
    emit(lw(5'd2, 5'd0, 12'd4));
    alu_case(enc_r(7'h00, f3_add, 3, 1, 2), a + b);
    alu_case(enc_r(7'h20, f3_add, 3, 1, 2), a - b);
    alu_case(enc_r(7'h00, f3_and, 3, 1, 2), a & b);
    alu_case(enc_r(7'h00, f3_or, 3, 1, 2), a | b);
    alu_case(enc_r(7'h00, f3_xor, 3, 1, 2), a ^ b);
    alu_case(enc_r(7'h00, f3_slt, 3, 1, 2), signed_less(a, b));
    alu_case(enc_r(7'h00, f3_sltu, 3, 1, 2), (a < b) ? 32'd1 : 32'd0);
    alu_case(enc_r(7'h00, f3_sll, 3, 1, 2), a << b[4:0]);
    alu_case(enc_r(7'h00, f3_sr, 3, 1, 2), a >> b[4:0]);
    alu_case(enc_r(7'h20, f3_sr, 3, 1, 2), shift_right_arith(a, b[4:0]));
    alu_case(enc_i(op_imm, f3_add, 3, 1, imm), a + iv);
    alu_case(enc_i(op_imm, f3_and, 3, 1, imm), a & iv);
    alu_case(enc_i(op_imm, f3_or, 3, 1, imm), a | iv);
    alu_case(enc_i(op_imm, f3_xor, 3, 1, imm), a ^ iv);
    alu_case(enc_i(op_imm, f3_slt, 3, 1, imm), signed_less(a, iv));
    alu_case(enc_i(op_imm, f3_sltu, 3, 1, imm), (a < iv) ? 32'd1 : 32'd0);
    alu_case(enc_i(op_imm, f3_sll, 3, 1, {7'h00, sh}), a << sh);
    alu_case(enc_i(op_imm, f3_sr, 3, 1, {7'h00, sh}), a >> sh);
    alu_case(enc_i(op_imm, f3_sr, 3, 1, {7'h20, sh}), shift_right_arith(a, sh));
    alu_case(enc_u(5'd3, up), {up, 12'h000});
    run_program(done);
    if (done) begin
      check_slots(16, expect_q.size());
    end
    end_test("alu_ops", err_mark);
  endtask

  task automatic test_forwarding();
    logic [31:0] c, d;
    bit          done;
    int unsigned err_mark;
    err_mark = n_errors;
    c = $urandom();
    d = $urandom();
    start_program();
    mem.put_ram(0, c);
    mem.put_ram(1, d);
    emit(lw(5'd1, 5'd0, 12'd0));
    emit(enc_r(7'h00, f3_add, 2, 1, 1));
    emit(addi(5'd3, 5'd2, 12'd5));
    emit(enc_r(7'h00, f3_add, 4, 3, 2));
    emit(enc_r(7'h20, f3_add, 5, 4, 1));
    emit(enc_r(7'h00, f3_add, 6, 5, 5));
    emit(sw(5'd6, 5'd0, 12'd64));
    emit(sw(5'd2, 5'd0, 12'd68));
    emit(sw(5'd3, 5'd0, 12'd72));
    emit(sw(5'd4, 5'd0, 12'd76));
    emit(sw(5'd5, 5'd0, 12'd80));
    emit(lw(5'd7, 5'd0, 12'd4));
    emit(sw(5'd7, 5'd0, 12'd84));
    emit(lw(5'd8, 5'd0, 12'd4));
    emit(addi(5'd9, 5'd8, 12'hfff));
    emit(sw(5'd9, 5'd0, 12'd88));
    // Store base comes straight from the previous instruction
    emit(addi(5'd10, 5'd0, 12'd92));
    emit(sw(5'd6, 5'd10, 12'd0));
    expect_q = '{6 * c + 10, 2 * c, 2 * c + 5, 4 * c + 5, 3 * c + 5, d, d - 1, 6 * c + 10};
    run_program(done);
    if (done) begin
      check_slots(16, 8);
    end
    end_test("forwarding", err_mark);
  endtask

  // Taken jumps over the not-taken store, not taken runs it and then jumps
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                             input bit taken);
    logic [11:0] addr;
    addr = 12'(64 + 4 * expect_q.size());
    emit(enc_b(f3, rs1, rs2, 13'd12));
    emit(sw(5'd11, 5'd0, addr));
    emit(enc_j(5'd0, 21'd8));
    emit(sw(5'd12, 5'd0, addr));
    expect_q.push_back(taken ? 32'h222 : 32'h111);
  endtask

  task automatic test_branches();
    bit          done;
    int unsigned err_mark;
    err_mark = n_errors;
    start_program();
    emit(addi(5'd1, 5'd0, 12'd5));
    emit(addi(5'd2, 5'd0, 12'hffd));
    emit(addi(5'd3, 5'd0, 12'd5));
    emit(addi(5'd11, 5'd0, 12'h111));
    emit(addi(5'd12, 5'd0, 12'h222));
    branch_case(f3_beq, 1, 3, 1'b1);
    branch_case(f3_beq, 1, 2, 1'b0);
    branch_case(f3_bne, 1, 2, 1'b1);
    branch_case(f3_bne, 1, 3, 1'b0);
    branch_case(f3_blt, 2, 1, 1'b1);
    branch_case(f3_blt, 1, 2, 1'b0);
    branch_case(f3_bge, 1, 2, 1'b1);
    branch_case(f3_bge, 2, 1, 1'b0);
    branch_case(f3_bltu, 1, 2, 1'b1);
    branch_case(f3_bltu, 2, 1, 1'b0);
    branch_case(f3_bgeu, 2, 1, 1'b1);
    branch_case(f3_bgeu, 1, 2, 1'b0);
    run_program(done);
    if (done) begin
      // Words below the result slots keep their fill pattern
      for (int i = 0; i < 16; i++) begin
        check($sformatf("ram[%0d]", i), mem.ram[i], fill_word(i));
      end
      check_slots(16, 16);
      check("store_count", mem.store_count, 32'd13);
    end
    end_test("branches", err_mark);
  endtask

  task automatic test_jumps();
    int unsigned j0, k;
    bit          done;
    int unsigned err_mark;
    err_mark = n_errors;
    start_program();
    emit(addi(5'd10, 5'd0, 12'h666));
    j0 = pc_idx;
    emit(enc_j(5'd1, 21'd12));
    emit(sw(5'd10, 5'd0, 12'd64));
    emit(sw(5'd10, 5'd0, 12'd68));
    emit(sw(5'd1, 5'd0, 12'd72));
    // Base plus one is odd, the landing store sits at the even address
    k = pc_idx;
    emit(addi(5'd5, 5'd0, 12'(4 * (k + 4))));
    emit(enc_i(op_jalr, 3'b000, 5'd2, 5'd5, 12'd1));
    emit(sw(5'd10, 5'd0, 12'd76));
    emit(sw(5'd10, 5'd0, 12'd80));
    emit(sw(5'd2, 5'd0, 12'd84));
    expect_q = '{fill_word(16), fill_word(17), 4 * j0 + 4,
                 fill_word(19), fill_word(20), 4 * (k + 1) + 4};
    run_program(done);
    if (done) begin
      check_slots(16, 6);
      check("store_count", mem.store_count, 32'd3);
    end
    end_test("jumps", err_mark);
  endtask

  initial begin
    int unsigned seed;
    seed     = 32'hc742a215;
    n_tests  = 0;
    n_checks = 0;
    n_errors = 0;
    pc_idx   = 0;
    void'($urandom(seed));
    #1;
    clkgen.hold_reset();
    #9;
    test_reset_state();
    clkgen.release_reset();
    test_alu();
    test_forwarding();
    test_branches();
    test_jumps();
    $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hdl/rv32_pkg.sv
hdl/fetch_dec_if.sv
hdl/dec_exe_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/rv32_core.sv
tb/tb_clock.sv
tb/core_mem_model.sv
tb/rv32_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv32_core

sources:
  - files:
      - hdl/rv32_pkg.sv
      - hdl/fetch_dec_if.sv
      - hdl/dec_exe_if.sv
      - hdl/fetch_stage.sv
      - hdl/decode_stage.sv
      - hdl/execute_stage.sv
      - hdl/rv32_core.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/core_mem_model.sv
      - tb/rv32_core_tb.sv
